// ==== verilog/binarize_config.svh ====
`ifndef BINARIZE_CONFIG_SVH
`define BINARIZE_CONFIG_SVH

// Image geometry.
`define IMG_COLS 32
`define IMG_ROWS 24

// The adder tree is built for exactly 13 taps, so WIN is fixed.
`define WIN      13

// Pixels in one window.
`define WIN_AREA 169

`endif

// ==== verilog/binarize_pkg.sv ====
`default_nettype none

`include "binarize_config.svh"

package binarize_pkg;

    // One grey-scale sample.
    typedef logic [7:0] pixel_t;

    // 13 pixels, max 3315.
    typedef logic [11:0] col_sum_t;

    // 169 pixels, max 43095.
    typedef logic [15:0] win_sum_t;

    // Scan position.
    typedef logic [$clog2(`IMG_COLS)-1:0] col_idx_t;
    typedef logic [$clog2(`IMG_ROWS)-1:0] row_idx_t;

endpackage

`default_nettype wire

// ==== verilog/scan_ctrl.sv ====
`default_nettype none

`include "binarize_config.svh"

module scan_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_pix_valid,
    output binarize_pkg::col_idx_t      o_col,
    output logic                        o_row_start,
    output logic                        o_sub_phase,
    output logic                        o_out_en
);

    localparam binarize_pkg::col_idx_t last_col = binarize_pkg::col_idx_t'(`IMG_COLS - 1);
    localparam binarize_pkg::row_idx_t last_row = binarize_pkg::row_idx_t'(`IMG_ROWS - 1);

    // First column and row where a full window is available.
    localparam binarize_pkg::col_idx_t full_col = binarize_pkg::col_idx_t'(`WIN - 1);
    localparam binarize_pkg::row_idx_t full_row = binarize_pkg::row_idx_t'(`WIN - 1);

    // The column leaving the window exists from here on.
    localparam binarize_pkg::col_idx_t sub_col = binarize_pkg::col_idx_t'(`WIN);

    binarize_pkg::col_idx_t col;
    binarize_pkg::row_idx_t row;

    logic at_last_col;
    logic at_last_row;

    assign at_last_col = (col == last_col);
    assign at_last_row = (row == last_row);

    // Position counters, advanced per accepted pixel.
    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
            row <= '0;
        end else if (i_pix_valid) begin
            if (at_last_col) begin
                col <= '0;
                row <= at_last_row ? '0 : row + 1'b1;  // Wraps into the next frame.
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Phase flags of the accepted pixel, aligned with the tap register.
    always_ff @(posedge clk) begin
        if (rst) begin
            o_row_start <= 1'b0;
            o_sub_phase <= 1'b0;
            o_out_en    <= 1'b0;
        end else if (i_pix_valid) begin
            o_row_start <= (col == '0);
            o_sub_phase <= (col >= sub_col);
            o_out_en    <= (row >= full_row) && (col >= full_col);
        end
    end

    // Address for the line memories.
    assign o_col = col;

endmodule

`default_nettype wire

// ==== verilog/line_buffer.sv ====
`default_nettype none

`include "binarize_config.svh"

module line_buffer (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire                                     i_pix_valid,
    input  wire binarize_pkg::pixel_t               i_pix,
    input  wire binarize_pkg::col_idx_t             i_col,
    output logic                                    o_tap_valid,
    output binarize_pkg::pixel_t [`WIN-1:0]         o_tap
);

    localparam int n_lines = `WIN - 1;

    // line_mem[k] holds the row that is k+1 rows above the incoming one.
    binarize_pkg::pixel_t line_mem [n_lines][`IMG_COLS];

    // Samples of the current column from all stored rows.
    binarize_pkg::pixel_t rd_pix [n_lines];

    always_comb begin
        for (int k = 0; k < n_lines; k++) begin
            rd_pix[k] = line_mem[k][i_col];
        end
    end

    // Vertical shift through the memories at the current column.
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            line_mem[0][i_col] <= i_pix;
            for (int k = 1; k < n_lines; k++) begin
                line_mem[k][i_col] <= rd_pix[k-1];
            end
        end
    end

    // Tap register, tap 0 newest.
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            o_tap[0] <= i_pix;
            for (int k = 0; k < n_lines; k++) begin
                o_tap[k+1] <= rd_pix[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_tap_valid <= 1'b0;
        end else begin
            o_tap_valid <= i_pix_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/column_adder.sv ====
`default_nettype none

`include "binarize_config.svh"

module column_adder (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire                                     i_valid,
    input  wire binarize_pkg::pixel_t [`WIN-1:0]    i_tap,
    output logic                                    o_valid,
    output binarize_pkg::col_sum_t                  o_col_sum
);

    localparam int n_pairs = (`WIN - 1) / 2;  // 6 pairs, tap 12 left over.
    localparam int n_quads = n_pairs / 2;

    // Level 1: pairs.
    logic [8:0]           s1_pair [n_pairs];
    binarize_pkg::pixel_t s1_odd;
    logic                 s1_valid;

    // Level 2: quads.
    logic [9:0]           s2_quad [n_quads];
    binarize_pkg::pixel_t s2_odd;
    logic                 s2_valid;

    // Level 3: two partial sums.
    logic [10:0]          s3_low;
    logic [10:0]          s3_high;
    logic                 s3_valid;

    // Data stages run every cycle, the valid tag marks real columns.
    always_ff @(posedge clk) begin
        for (int k = 0; k < n_pairs; k++) begin
            s1_pair[k] <= {1'b0, i_tap[2*k]} + {1'b0, i_tap[2*k+1]};
        end
        s1_odd <= i_tap[`WIN-1];

        for (int k = 0; k < n_quads; k++) begin
            s2_quad[k] <= {1'b0, s1_pair[2*k]} + {1'b0, s1_pair[2*k+1]};
        end
        s2_odd <= s1_odd;  // Odd tap waits for the quads.

        s3_low  <= {1'b0, s2_quad[0]} + {1'b0, s2_quad[1]};
        s3_high <= {1'b0, s2_quad[2]} + {3'b000, s2_odd};

        o_col_sum <= {1'b0, s3_low} + {1'b0, s3_high};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            o_valid  <= s3_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/window_accum.sv ====
`default_nettype none

`include "binarize_config.svh"

module window_accum (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_col_valid,
    input  wire binarize_pkg::col_sum_t     i_col_sum,
    input  wire                             i_tap_valid,
    input  wire binarize_pkg::pixel_t       i_center_tap,
    input  wire                             i_row_start,
    input  wire                             i_sub_phase,
    input  wire                             i_out_en,
    output logic                            o_out_valid,
    output binarize_pkg::win_sum_t          o_win_sum,
    output binarize_pkg::pixel_t            o_center,
    output logic                            o_bin
);

    localparam int tree_dly   = 4;               // Adder tree depth.
    localparam int center_dly = (`WIN - 1) / 2;  // Columns from right edge to centre.

    // Flags delayed to meet the column sum.
    logic [tree_dly-1:0] row_start_sr;
    logic [tree_dly-1:0] sub_phase_sr;
    logic [tree_dly-1:0] out_en_sr;

    // Column sums of the previous 13 columns, newest first.
    binarize_pkg::col_sum_t col_hist [`WIN];

    binarize_pkg::pixel_t center_dl   [center_dly];
    binarize_pkg::pixel_t center_pipe [tree_dly];

    binarize_pkg::win_sum_t col_term;
    binarize_pkg::win_sum_t old_term;
    binarize_pkg::win_sum_t win_next;

    binarize_pkg::win_sum_t win_sum;
    binarize_pkg::pixel_t   win_center;
    logic                   win_emit;
    binarize_pkg::win_sum_t center_scaled;

    always_ff @(posedge clk) begin
        if (rst) begin
            row_start_sr <= '0;
            sub_phase_sr <= '0;
            out_en_sr    <= '0;
        end else begin
            row_start_sr <= {row_start_sr[tree_dly-2:0], i_row_start};
            sub_phase_sr <= {sub_phase_sr[tree_dly-2:0], i_sub_phase};
            out_en_sr    <= {out_en_sr[tree_dly-2:0], i_out_en};
        end
    end

    always_ff @(posedge clk) begin
        if (i_col_valid) begin
            col_hist[0] <= i_col_sum;
            for (int k = 1; k < `WIN; k++) begin
                col_hist[k] <= col_hist[k-1];
            end
        end
    end

    // Centre of the window is six pixels back on the middle tap.
    always_ff @(posedge clk) begin
        if (i_tap_valid) begin
            center_dl[0] <= i_center_tap;
            for (int k = 1; k < center_dly; k++) begin
                center_dl[k] <= center_dl[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        center_pipe[0] <= center_dl[center_dly-1];
        for (int k = 1; k < tree_dly; k++) begin
            center_pipe[k] <= center_pipe[k-1];
        end
    end

    always_comb begin
        col_term = binarize_pkg::win_sum_t'(i_col_sum);
        old_term = sub_phase_sr[tree_dly-1] ? binarize_pkg::win_sum_t'(col_hist[`WIN-1]) : '0;
        win_next = row_start_sr[tree_dly-1] ? col_term : win_sum + col_term - old_term;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_sum  <= '0;
            win_emit <= 1'b0;
        end else begin
            win_emit <= i_col_valid & out_en_sr[tree_dly-1];
            if (i_col_valid) begin
                win_sum <= win_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        win_center <= center_pipe[tree_dly-1];
    end

    // Brighter than the local mean.
    assign center_scaled = binarize_pkg::win_sum_t'(win_center)
                         * binarize_pkg::win_sum_t'(`WIN_AREA);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_out_valid <= 1'b0;
            o_win_sum   <= '0;
        end else begin
            o_out_valid <= win_emit;
            o_win_sum   <= win_sum;
        end
    end

    always_ff @(posedge clk) begin
        o_center <= win_center;
        o_bin    <= (center_scaled > win_sum);
    end

endmodule

`default_nettype wire

// ==== verilog/adaptive_binarize_top.sv ====
`default_nettype none

`include "binarize_config.svh"

module adaptive_binarize_top (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_pix_valid,
    input  wire binarize_pkg::pixel_t       i_pix,
    output logic                            o_out_valid,
    output binarize_pkg::win_sum_t          o_win_sum,
    output binarize_pkg::pixel_t            o_center,
    output logic                            o_bin
);

    localparam int mid_tap = (`WIN - 1) / 2;

    binarize_pkg::col_idx_t             col;
    logic                               row_start;
    logic                               sub_phase;
    logic                               out_en;
    logic                               tap_valid;
    binarize_pkg::pixel_t [`WIN-1:0]    tap;
    logic                               col_valid;
    binarize_pkg::col_sum_t             col_sum;

    scan_ctrl u_scan_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .o_col       (col),
        .o_row_start (row_start),
        .o_sub_phase (sub_phase),
        .o_out_en    (out_en)
    );

    line_buffer u_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .i_col       (col),
        .o_tap_valid (tap_valid),
        .o_tap       (tap)
    );

    column_adder u_column_adder (
        .clk       (clk),
        .rst       (rst),
        .i_valid   (tap_valid),
        .i_tap     (tap),
        .o_valid   (col_valid),
        .o_col_sum (col_sum)
    );

    window_accum u_window_accum (
        .clk          (clk),
        .rst          (rst),
        .i_col_valid  (col_valid),
        .i_col_sum    (col_sum),
        .i_tap_valid  (tap_valid),
        .i_center_tap (tap[mid_tap]),
        .i_row_start  (row_start),
        .i_sub_phase  (sub_phase),
        .i_out_en     (out_en),
        .o_out_valid  (o_out_valid),
        .o_win_sum    (o_win_sum),
        .o_center     (o_center),
        .o_bin        (o_bin)
    );

endmodule

`default_nettype wire

// ==== verification/adaptive_binarize_assertions.sv ====
`default_nettype none

`include "binarize_config.svh"

module adaptive_binarize_assertions (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_tap_valid,
    input  wire                             i_out_valid,
    input  wire binarize_pkg::win_sum_t     i_win_sum
);

    localparam binarize_pkg::win_sum_t max_win_sum =
        binarize_pkg::win_sum_t'(`WIN_AREA * 255);

    // Tap valid trails the accepted pixel by one cycle.
    localparam int tap_to_out = 6;

    int failures = 0;

    property no_output_near_reset;
        @(posedge clk) i_out_valid |->
            !rst && !$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)
            && !$past(rst, 4) && !$past(rst, 5) && !$past(rst, 6) && !$past(rst, 7);
    endproperty

    property fixed_latency;
        @(posedge clk) disable iff (rst)
            i_out_valid |-> $past(i_tap_valid, tap_to_out);
    endproperty

    property sum_in_range;
        @(posedge clk) disable iff (rst)
            i_out_valid |-> (i_win_sum <= max_win_sum);
    endproperty

    a_reset_quiet: assert property (no_output_near_reset) else begin
        $error("Output valid during reset or within 7 cycles after it.");
        failures++;
    end

    a_latency: assert property (fixed_latency) else begin
        $error("Output valid without a pixel accepted 7 cycles earlier.");
        failures++;
    end

    a_sum_range: assert property (sum_in_range) else begin
        $error("Window sum above the largest possible value.");
        failures++;
    end

endmodule

bind window_accum adaptive_binarize_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .i_tap_valid (i_tap_valid),
    .i_out_valid (o_out_valid),
    .i_win_sum   (o_win_sum)
);

`default_nettype wire

// ==== verification/tb_adaptive_binarize.sv ====
`default_nettype none

`include "binarize_config.svh"

module tb_adaptive_binarize;

    localparam int seed           = 98154;
    localparam int n_frames       = 3;
    localparam int half_win       = (`WIN - 1) / 2;
    localparam int max_cycles     = 8000;  // 3 x 768 pixels at about 4/3 cycles, plus margin.
    localparam int tail_cycles    = 16;
    localparam int flat_cols      = 16;    // Frame 1 is flat left of this column.
    localparam int bright_rows    = 18;    // Frame 2 is saturated above this row.
    localparam int outs_per_frame = (`IMG_ROWS - `WIN + 1) * (`IMG_COLS - `WIN + 1);

    logic                   clk;
    logic                   rst;
    logic                   i_pix_valid;
    binarize_pkg::pixel_t   i_pix;
    logic                   o_out_valid;
    binarize_pkg::win_sum_t o_win_sum;
    binarize_pkg::pixel_t   o_center;
    logic                   o_bin;

    // Reference copy of the frame being received.
    int frame_img [`IMG_ROWS][`IMG_COLS];

    int    exp_sum_q    [$];
    int    exp_center_q [$];
    logic  exp_bin_q    [$];
    string exp_pos_q    [$];

    int m_row   = 0;
    int m_col   = 0;
    int m_frame = 0;

    int cycle_count      = 0;
    int out_count        = 0;
    int mismatch_count   = 0;
    int unexpected_count = 0;
    int run_errors       = 0;

    adaptive_binarize_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_out_valid (o_out_valid),
        .o_win_sum   (o_win_sum),
        .o_center    (o_center),
        .o_bin       (o_bin)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Random content with flat and saturated regions in the later frames.
    function automatic binarize_pkg::pixel_t gen_pixel(input int frame, input int row,
                                                       input int col);
        binarize_pkg::pixel_t value;
        value = binarize_pkg::pixel_t'($urandom);
        if (frame == 1 && col < flat_cols) begin
            value = 8'd100;
        end else if (frame == 2) begin
            if (row < bright_rows) begin
                value = 8'd255;
            end else begin
                value = value[0] ? 8'd255 : 8'd0;
            end
        end
        return value;
    endfunction

    function automatic int window_sum(input int row, input int col);
        int sum;
        sum = 0;
        for (int r = row - `WIN + 1; r <= row; r++) begin
            for (int c = col - `WIN + 1; c <= col; c++) begin
                sum += frame_img[r][c];
            end
        end
        return sum;
    endfunction

    // Idle cycles in about one cycle of four come before the pixel.
    task automatic send_pixel(input binarize_pkg::pixel_t pix);
        while (($urandom % 4) == 0) begin
            i_pix_valid = 1'b0;
            i_pix       = binarize_pkg::pixel_t'($urandom);
            @(posedge clk);
            #1;
        end
        i_pix_valid = 1'b1;
        i_pix       = pix;
        @(posedge clk);
        #1;
    endtask

    task automatic model_pixel(input binarize_pkg::pixel_t pix);
        int sum;
        int centre;
        frame_img[m_row][m_col] = int'(pix);
        if (m_row >= `WIN - 1 && m_col >= `WIN - 1) begin
            sum    = window_sum(m_row, m_col);
            centre = frame_img[m_row - half_win][m_col - half_win];
            exp_sum_q.push_back(sum);
            exp_center_q.push_back(centre);
            exp_bin_q.push_back(centre * `WIN_AREA > sum);
            exp_pos_q.push_back($sformatf("frame %0d row %0d col %0d", m_frame, m_row, m_col));
        end
        if (m_col == `IMG_COLS - 1) begin
            m_col = 0;
            if (m_row == `IMG_ROWS - 1) begin
                m_row = 0;
                m_frame++;
            end else begin
                m_row++;
            end
        end else begin
            m_col++;
        end
    endtask

    task automatic check_output();
        int    exp_sum;
        int    exp_center;
        logic  exp_bin;
        string pos;
        assert (exp_sum_q.size() > 0) else begin
            unexpected_count++;
            $display("Output valid with no window pending, the DUT produced an extra result");
        end
        if (exp_sum_q.size() > 0) begin
            exp_sum    = exp_sum_q.pop_front();
            exp_center = exp_center_q.pop_front();
            exp_bin    = exp_bin_q.pop_front();
            pos        = exp_pos_q.pop_front();
            out_count++;
            assert (int'(o_win_sum) == exp_sum) else begin
                mismatch_count++;
                $display("MISMATCH window_sum at %s: expected %0d actual %0d",
                         pos, exp_sum, o_win_sum);
            end
            assert (int'(o_center) == exp_center) else begin
                mismatch_count++;
                $display("MISMATCH centre at %s: expected %0d actual %0d",
                         pos, exp_center, o_center);
            end
            assert (o_bin == exp_bin) else begin
                mismatch_count++;
                $display("MISMATCH binary at %s: expected %0d actual %0d",
                         pos, exp_bin, o_bin);
            end
        end
    endtask

    // Inputs change one unit after the edge, so both are stable here.
    always @(posedge clk) begin
        if (!rst) begin
            if (o_out_valid === 1'b1) begin
                check_output();
            end
            if (i_pix_valid === 1'b1) begin
                model_pixel(i_pix);
            end
        end
    end

    task automatic report_and_finish();
        int sva_failures;
        int total;
        sva_failures = u_dut.u_window_accum.u_assertions.failures;
        total = mismatch_count + unexpected_count + run_errors + sva_failures;
        $display("Error counts: %0d mismatches, %0d extra outputs, %0d run errors, %0d assertions",
                 mismatch_count, unexpected_count, run_errors, sva_failures);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(seed));
        rst         = 1'b1;
        i_pix_valid = 1'b0;
        i_pix       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int f = 0; f < n_frames; f++) begin
            for (int r = 0; r < `IMG_ROWS; r++) begin
                for (int c = 0; c < `IMG_COLS; c++) begin
                    send_pixel(gen_pixel(f, r, c));
                end
            end
        end
        i_pix_valid = 1'b0;

        while (exp_sum_q.size() != 0 && cycle_count < max_cycles) begin
            @(posedge clk);
        end

        assert (cycle_count < max_cycles) else begin
            run_errors++;
            $display("Timeout: the run reached the limit of %0d cycles", max_cycles);
        end

        repeat (tail_cycles) @(posedge clk);  // Catch any late extra output.

        assert (exp_sum_q.size() == 0) else begin
            run_errors++;
            $display("%0d expected outputs never arrived", exp_sum_q.size());
        end
        assert (out_count == n_frames * outs_per_frame) else begin
            mismatch_count++;
            $display("MISMATCH output_count: expected %0d actual %0d",
                     n_frames * outs_per_frame, out_count);
        end

        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/binarize_pkg.sv
verilog/scan_ctrl.sv
verilog/line_buffer.sv
verilog/column_adder.sv
verilog/window_accum.sv
verilog/adaptive_binarize_top.sv
verification/adaptive_binarize_assertions.sv
verification/tb_adaptive_binarize.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_adaptive_binarize
SRCS := vlog.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source file or the file list changes.
$(SIM): $(SRCS)
	verilator --binary --assert -Wno-fatal -f vlog.f \
		--top-module tb_adaptive_binarize -Mdir obj_dir

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
